//--- verilog/core_settings.svh
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// datapath and register file geometry
`define XLEN        32
`define REG_ADDR_W  4
`define REG_COUNT   16

// ebreak instruction word
`define EBREAK_INST 32'h0010_0073

`endif

//--- verilog/core_pkg.sv
package core_pkg;

    // alu operation selected by decode
    typedef enum logic [3:0] {
        ADD    = 4'd0,
        SUB    = 4'd1,
        AND    = 4'd2,
        OR     = 4'd3,
        XOR    = 4'd4,
        SLL    = 4'd5,
        SRL    = 4'd6,
        SLT    = 4'd7,
        PASS_B = 4'd8  // lui style, result is operand b
    } alu_op_e;

    // operation class, used for commit statistics
    typedef enum logic [2:0] {
        ALU    = 3'd0,
        SYSTEM = 3'd1,
        STORE  = 3'd2,
        LOAD   = 3'd3,
        BRANCH = 3'd4,
        JUMP   = 3'd5
    } op_class_e;

endpackage

//--- verilog/commit_if.sv
`timescale 1ns/1ps
`include "core_settings.svh"

interface commit_if;

    logic                   valid;
    logic                   ready;
    logic [`REG_ADDR_W-1:0] rd;
    logic                   rd_en;
    logic [`XLEN-1:0]       wdata;
    logic [`XLEN-1:0]       pc;     // trace only
    logic [`XLEN-1:0]       inst;
    core_pkg::op_class_e    op_class;

    modport execute (
        output valid,
        input  ready,
        output rd,
        output rd_en,
        output wdata,
        output pc,
        output inst,
        output op_class
    );

    modport writeback (
        input  valid,
        output ready,
        input  rd,
        input  rd_en,
        input  wdata,
        input  inst,
        input  op_class
    );

endinterface

//--- verilog/register_file.sv
`timescale 1ns/1ps
`include "core_settings.svh"

module register_file (
    input  logic                   clk,
    input  logic                   wen_i,
    input  logic [`REG_ADDR_W-1:0] waddr_i,
    input  logic [`XLEN-1:0]       wdata_i,
    input  logic [`REG_ADDR_W-1:0] raddr1_i,
    input  logic [`REG_ADDR_W-1:0] raddr2_i,
    output logic [`XLEN-1:0]       rdata1_o,
    output logic [`XLEN-1:0]       rdata2_o
);

    // x0 has no storage
    logic [`XLEN-1:0] regs [1:`REG_COUNT-1];

    always_ff @(posedge clk) begin
        if (wen_i && (waddr_i != '0)) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    always_comb begin
        if (raddr1_i == '0) begin
            rdata1_o = '0;
        end else begin
            rdata1_o = regs[raddr1_i];
        end
    end

    always_comb begin
        if (raddr2_i == '0) begin
            rdata2_o = '0;
        end else begin
            rdata2_o = regs[raddr2_i];
        end
    end

endmodule

//--- verilog/execute_stage.sv
`timescale 1ns/1ps
`include "core_settings.svh"

module execute_stage (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   issue_valid_i,
    output logic                   issue_ready_o,
    input  core_pkg::alu_op_e      issue_op_i,
    input  core_pkg::op_class_e    issue_class_i,
    input  logic [`REG_ADDR_W-1:0] issue_rd_i,
    input  logic                   issue_rd_en_i,
    input  logic [`REG_ADDR_W-1:0] issue_rs1_i,
    input  logic [`REG_ADDR_W-1:0] issue_rs2_i,
    input  logic                   issue_use_imm_i,
    input  logic [`XLEN-1:0]       issue_imm_i,
    input  logic [`XLEN-1:0]       issue_pc_i,
    input  logic [`XLEN-1:0]       issue_inst_i,
    output logic [`REG_ADDR_W-1:0] raddr1_o,
    output logic [`REG_ADDR_W-1:0] raddr2_o,
    input  logic [`XLEN-1:0]       rdata1_i,
    input  logic [`XLEN-1:0]       rdata2_i,
    input  logic                   halt_i,
    commit_if.execute              commit
);

    logic                   issue_fire;
    logic                   commit_fire;
    logic [`XLEN-1:0]       op_a;
    logic [`XLEN-1:0]       op_b;
    logic [`XLEN-1:0]       alu_result;
    logic                   uses_rs1;
    logic                   uses_rs2;
    logic                   hazard;

    logic                   out_valid;
    logic [`REG_ADDR_W-1:0] out_rd;
    logic                   out_rd_en;
    logic [`XLEN-1:0]       out_wdata;
    logic [`XLEN-1:0]       out_pc;
    logic [`XLEN-1:0]       out_inst;
    core_pkg::op_class_e    out_class;

    assign raddr1_o = issue_rs1_i;
    assign raddr2_o = issue_rs2_i;

    assign op_a = rdata1_i;
    assign op_b = issue_use_imm_i ? issue_imm_i : rdata2_i;

    always_comb begin
        case (issue_op_i)
            core_pkg::ADD:    alu_result = op_a + op_b;
            core_pkg::SUB:    alu_result = op_a - op_b;
            core_pkg::AND:    alu_result = op_a & op_b;
            core_pkg::OR:     alu_result = op_a | op_b;
            core_pkg::XOR:    alu_result = op_a ^ op_b;
            core_pkg::SLL:    alu_result = op_a << op_b[4:0];
            core_pkg::SRL:    alu_result = op_a >> op_b[4:0];
            core_pkg::SLT:    alu_result = {{(`XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            core_pkg::PASS_B: alu_result = op_b;
            default:          alu_result = '0;
        endcase
    end

    // result in the output register is not in the regfile yet
    assign uses_rs1 = (issue_op_i != core_pkg::PASS_B);
    assign uses_rs2 = !issue_use_imm_i;

    always_comb begin
        hazard = 1'b0;
        if (out_valid && out_rd_en && (out_rd != '0)) begin
            if (uses_rs1 && (out_rd == issue_rs1_i)) begin
                hazard = 1'b1;
            end
            if (uses_rs2 && (out_rd == issue_rs2_i)) begin
                hazard = 1'b1;
            end
        end
    end

    assign issue_ready_o = !halt_i && !hazard && (!out_valid || commit.ready);

    assign issue_fire  = issue_valid_i && issue_ready_o;
    assign commit_fire = out_valid && commit.ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else if (issue_fire) begin
            out_valid <= 1'b1;  // refill on same edge as transfer
        end else if (commit_fire) begin
            out_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (issue_fire) begin
            out_rd    <= issue_rd_i;
            out_rd_en <= issue_rd_en_i;
            out_wdata <= alu_result;
            out_pc    <= issue_pc_i;
            out_inst  <= issue_inst_i;
            out_class <= issue_class_i;
        end
    end

    assign commit.valid    = out_valid;
    assign commit.rd       = out_rd;
    assign commit.rd_en    = out_rd_en;
    assign commit.wdata    = out_wdata;
    assign commit.pc       = out_pc;
    assign commit.inst     = out_inst;
    assign commit.op_class = out_class;

endmodule

//--- verilog/writeback_stage.sv
`timescale 1ns/1ps
`include "core_settings.svh"

module writeback_stage (
    input  logic                   clk,
    input  logic                   reset,
    commit_if.writeback            commit,
    input  logic [`REG_ADDR_W-1:0] raddr1_i,
    input  logic [`REG_ADDR_W-1:0] raddr2_i,
    output logic [`XLEN-1:0]       rdata1_o,
    output logic [`XLEN-1:0]       rdata2_o,
    output logic                   halt_o,
    output logic [31:0]            commit_count_o,
    input  core_pkg::op_class_e    stat_sel_i,
    output logic [31:0]            stat_count_o
);

    logic        commit_fire;
    logic        reg_wen;
    logic        is_ebreak;
    logic        class_valid;
    logic        halt_q;
    logic [31:0] total_count;
    logic [31:0] class_count [0:core_pkg::JUMP];

    // write-back never stalls
    assign commit.ready = 1'b1;

    assign commit_fire = commit.valid && commit.ready;
    assign reg_wen     = commit_fire && commit.rd_en;  // rd 0 dropped in regfile

    assign is_ebreak = (commit.op_class == core_pkg::SYSTEM) &&
                       (commit.inst == `EBREAK_INST);

    assign class_valid = (commit.op_class <= core_pkg::JUMP);

    always_ff @(posedge clk) begin
        if (reset) begin
            total_count <= '0;
        end else if (commit_fire) begin
            total_count <= total_count + 32'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i <= core_pkg::JUMP; i++) begin
                class_count[i] <= '0;
            end
        end else if (commit_fire && class_valid) begin
            class_count[commit.op_class] <= class_count[commit.op_class] + 32'd1;
        end
    end

    // sticky until reset
    always_ff @(posedge clk) begin
        if (reset) begin
            halt_q <= 1'b0;
        end else if (commit_fire && is_ebreak) begin
            halt_q <= 1'b1;
        end
    end

    always_comb begin
        if (stat_sel_i <= core_pkg::JUMP) begin
            stat_count_o = class_count[stat_sel_i];
        end else begin
            stat_count_o = '0;
        end
    end

    assign commit_count_o = total_count;
    assign halt_o         = halt_q;

    register_file u_register_file (
        .clk      (clk),
        .wen_i    (reg_wen),
        .waddr_i  (commit.rd),
        .wdata_i  (commit.wdata),
        .raddr1_i (raddr1_i),
        .raddr2_i (raddr2_i),
        .rdata1_o (rdata1_o),
        .rdata2_o (rdata2_o)
    );

endmodule

//--- verilog/exec_wb_top.sv
`timescale 1ns/1ps
`include "core_settings.svh"

module exec_wb_top (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   issue_valid_i,
    output logic                   issue_ready_o,
    input  core_pkg::alu_op_e      issue_op_i,
    input  core_pkg::op_class_e    issue_class_i,
    input  logic [`REG_ADDR_W-1:0] issue_rd_i,
    input  logic                   issue_rd_en_i,
    input  logic [`REG_ADDR_W-1:0] issue_rs1_i,
    input  logic [`REG_ADDR_W-1:0] issue_rs2_i,
    input  logic                   issue_use_imm_i,
    input  logic [`XLEN-1:0]       issue_imm_i,
    input  logic [`XLEN-1:0]       issue_pc_i,
    input  logic [`XLEN-1:0]       issue_inst_i,
    output logic                   commit_valid_o,
    output logic [`REG_ADDR_W-1:0] commit_rd_o,
    output logic                   commit_rd_en_o,
    output logic [`XLEN-1:0]       commit_wdata_o,
    output logic [`XLEN-1:0]       commit_pc_o,
    output logic                   halt_o,
    output logic [31:0]            commit_count_o,
    input  core_pkg::op_class_e    stat_sel_i,
    output logic [31:0]            stat_count_o
);

    logic [`REG_ADDR_W-1:0] raddr1;
    logic [`REG_ADDR_W-1:0] raddr2;
    logic [`XLEN-1:0]       rdata1;
    logic [`XLEN-1:0]       rdata2;
    logic                   halt;

    commit_if commit_bus ();

    execute_stage u_execute_stage (
        .clk             (clk),
        .reset           (reset),
        .issue_valid_i   (issue_valid_i),
        .issue_ready_o   (issue_ready_o),
        .issue_op_i      (issue_op_i),
        .issue_class_i   (issue_class_i),
        .issue_rd_i      (issue_rd_i),
        .issue_rd_en_i   (issue_rd_en_i),
        .issue_rs1_i     (issue_rs1_i),
        .issue_rs2_i     (issue_rs2_i),
        .issue_use_imm_i (issue_use_imm_i),
        .issue_imm_i     (issue_imm_i),
        .issue_pc_i      (issue_pc_i),
        .issue_inst_i    (issue_inst_i),
        .raddr1_o        (raddr1),
        .raddr2_o        (raddr2),
        .rdata1_i        (rdata1),
        .rdata2_i        (rdata2),
        .halt_i          (halt),   // stops issue after ebreak
        .commit          (commit_bus.execute)
    );

    writeback_stage u_writeback_stage (
        .clk            (clk),
        .reset          (reset),
        .commit         (commit_bus.writeback),
        .raddr1_i       (raddr1),
        .raddr2_i       (raddr2),
        .rdata1_o       (rdata1),
        .rdata2_o       (rdata2),
        .halt_o         (halt),
        .commit_count_o (commit_count_o),
        .stat_sel_i     (stat_sel_i),
        .stat_count_o   (stat_count_o)
    );

    // commit trace
    assign commit_valid_o = commit_bus.valid;
    assign commit_rd_o    = commit_bus.rd;
    assign commit_rd_en_o = commit_bus.rd_en;
    assign commit_wdata_o = commit_bus.wdata;
    assign commit_pc_o    = commit_bus.pc;
    assign halt_o         = halt;

endmodule

//--- sim/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk_o,
    output logic reset_o
);

    initial begin
        clk_o = 1'b0;
        forever #50 clk_o = ~clk_o;  // 100 ns period
    end

    initial begin
        reset_o = 1'b1;
        repeat (5) @(posedge clk_o);
        @(negedge clk_o);
        reset_o = 1'b0;
    end

endmodule

//--- sim/exec_wb_chk.sv
`timescale 1ns/1ps
`include "core_settings.svh"

module exec_wb_chk (
    input logic                   clk,
    input logic                   reset,
    input logic                   issue_valid_i,
    input logic                   issue_ready_o,
    input core_pkg::alu_op_e      issue_op_i,
    input core_pkg::op_class_e    issue_class_i,
    input logic [`REG_ADDR_W-1:0] issue_rd_i,
    input logic                   issue_rd_en_i,
    input logic [`REG_ADDR_W-1:0] issue_rs1_i,
    input logic [`REG_ADDR_W-1:0] issue_rs2_i,
    input logic                   issue_use_imm_i,
    input logic [`XLEN-1:0]       issue_imm_i,
    input logic [`XLEN-1:0]       issue_pc_i,
    input logic [`XLEN-1:0]       issue_inst_i,
    input logic                   commit_valid_o,
    input logic [`REG_ADDR_W-1:0] commit_rd_o,
    input logic                   commit_rd_en_o,
    input logic [`XLEN-1:0]       commit_wdata_o,
    input logic [`XLEN-1:0]       commit_pc_o,
    input logic                   halt_o,
    input logic [31:0]            commit_count_o,
    input core_pkg::op_class_e    stat_sel_i,
    input logic [31:0]            stat_count_o
);

    logic [`XLEN-1:0]       shadow [0:`REG_COUNT-1];
    logic [`XLEN-1:0]       op_b;
    logic [`XLEN-1:0]       result;
    logic [`XLEN-1:0]       exp_wdata;
    logic [`XLEN-1:0]       exp_pc;
    logic [31:0]            issued;
    logic [31:0]            class_issued [0:5];
    logic                   accept;
    logic                   pend_valid;
    logic [`REG_ADDR_W-1:0] pend_rd;
    logic                   pend_rd_en;
    core_pkg::op_class_e    pend_class;
    logic                   pend_ebreak;
    logic                   hazard;
    logic [31:0]            stat_expect;
    int                     fail_count = 0;

    function automatic logic [`XLEN-1:0] alu_model(input core_pkg::alu_op_e op,
                                                   input logic [`XLEN-1:0] a,
                                                   input logic [`XLEN-1:0] b);
        case (op)
            core_pkg::ADD: return a + b;
            core_pkg::SUB: return a - b;
            core_pkg::AND: return a & b;
            core_pkg::OR:  return a | b;
            core_pkg::XOR: return a ^ b;
            core_pkg::SLL: return a << b[4:0];
            core_pkg::SRL: return a >> b[4:0];
            core_pkg::SLT: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            default:       return b;
        endcase
    endfunction

    assign accept = issue_valid_i && issue_ready_o;

    assign op_b   = issue_use_imm_i ? issue_imm_i : shadow[issue_rs2_i];
    assign result = alu_model(issue_op_i, shadow[issue_rs1_i], op_b);

    // producer still waiting in the output register
    assign hazard = pend_valid && pend_rd_en && (pend_rd != '0) &&
                    (((issue_op_i != core_pkg::PASS_B) && (pend_rd == issue_rs1_i)) ||
                     (!issue_use_imm_i && (pend_rd == issue_rs2_i)));

    assign stat_expect = class_issued[stat_sel_i] -
                         ((pend_valid && (pend_class == stat_sel_i)) ? 32'd1 : 32'd0);

    always_ff @(posedge clk) begin
        if (reset) begin
            issued <= '0;
            pend_valid <= 1'b0;
            pend_ebreak <= 1'b0;
            for (int i = 0; i < `REG_COUNT; i++) begin
                shadow[i] <= '0;
            end
            for (int i = 0; i < 6; i++) begin
                class_issued[i] <= '0;
            end
        end else begin
            pend_valid <= accept;  // commits on the next edge
            if (accept) begin
                exp_wdata <= result;
                exp_pc <= issue_pc_i;
                if (issue_rd_en_i && (issue_rd_i != '0)) begin
                    shadow[issue_rd_i] <= result;  // x0 stays zero
                end
                issued <= issued + 32'd1;
                class_issued[issue_class_i] <= class_issued[issue_class_i] + 32'd1;
                pend_rd <= issue_rd_i;
                pend_rd_en <= issue_rd_en_i;
                pend_class <= issue_class_i;
                pend_ebreak <= (issue_class_i == core_pkg::SYSTEM) &&
                               (issue_inst_i == `EBREAK_INST);
            end
        end
    end

    a_result: assert property (@(posedge clk) disable iff (reset)
        pend_valid |-> commit_wdata_o == exp_wdata)
    else begin
        $error("Fail commit_wdata_o expected %h actual %h",
               $sampled(exp_wdata), $sampled(commit_wdata_o));
        fail_count++;
    end

    a_valid: assert property (@(posedge clk) disable iff (reset)
        commit_valid_o == pend_valid)
    else begin
        $error("Fail commit_valid_o expected %h actual %h",
               $sampled(pend_valid), $sampled(commit_valid_o));
        fail_count++;
    end

    a_trace: assert property (@(posedge clk) disable iff (reset)
        pend_valid |-> (commit_rd_o == pend_rd && commit_rd_en_o == pend_rd_en &&
                        commit_pc_o == exp_pc))
    else begin
        $error("Fail commit_rd_o/rd_en_o/pc_o expected %h %h %h actual %h %h %h",
               $sampled(pend_rd), $sampled(pend_rd_en), $sampled(exp_pc),
               $sampled(commit_rd_o), $sampled(commit_rd_en_o), $sampled(commit_pc_o));
        fail_count++;
    end

    a_interlock: assert property (@(posedge clk) disable iff (reset)
        (issue_valid_i && !halt_o) |-> issue_ready_o == !hazard)
    else begin
        $error("Fail issue_ready_o expected %h actual %h",
               !$sampled(hazard), $sampled(issue_ready_o));
        fail_count++;
    end

    a_one_stall: assert property (@(posedge clk) disable iff (reset)
        (issue_valid_i && !issue_ready_o && !halt_o) |=> (issue_ready_o || halt_o))
    else begin
        $error("issue stalled for more than one cycle");
        fail_count++;
    end

    a_count: assert property (@(posedge clk) disable iff (reset)
        commit_count_o == issued - pend_valid)
    else begin
        $error("Fail commit_count_o expected %h actual %h",
               $sampled(issued - pend_valid), $sampled(commit_count_o));
        fail_count++;
    end

    a_stat: assert property (@(posedge clk) disable iff (reset)
        stat_count_o == stat_expect)
    else begin
        $error("Fail stat_count_o expected %h actual %h",
               $sampled(stat_expect), $sampled(stat_count_o));
        fail_count++;
    end

    a_halt_rise: assert property (@(posedge clk) disable iff (reset)
        (pend_valid && pend_ebreak) |=> halt_o)
    else begin
        $error("halt did not rise after ebreak commit");
        fail_count++;
    end

    a_halt_block: assert property (@(posedge clk) disable iff (reset)
        halt_o |-> !issue_ready_o)
    else begin
        $error("issue was ready while halted");
        fail_count++;
    end

    a_halt_hold: assert property (@(posedge clk) disable iff (reset)
        halt_o |=> (halt_o && !commit_valid_o))
    else begin
        $error("halt dropped, or a commit went on while halted");
        fail_count++;
    end

    a_reset_state: assert property (@(posedge clk)
        $fell(reset) |-> (issue_ready_o && !commit_valid_o && !halt_o &&
                          commit_count_o == '0))
    else begin
        $error("outputs not in reset state after reset");
        fail_count++;
    end

endmodule

bind exec_wb_top exec_wb_chk u_chk (.*);

//--- sim/exec_wb_tb.sv
`timescale 1ns/1ps
`include "core_settings.svh"

module exec_wb_tb;

    localparam int MAX_CYCLES = 1200;  // 400 ops, one stall each, margin

    logic                   clk;
    logic                   reset;
    logic                   issue_valid_i;
    logic                   issue_ready_o;
    core_pkg::alu_op_e      issue_op_i;
    core_pkg::op_class_e    issue_class_i;
    logic [`REG_ADDR_W-1:0] issue_rd_i;
    logic                   issue_rd_en_i;
    logic [`REG_ADDR_W-1:0] issue_rs1_i;
    logic [`REG_ADDR_W-1:0] issue_rs2_i;
    logic                   issue_use_imm_i;
    logic [`XLEN-1:0]       issue_imm_i;
    logic [`XLEN-1:0]       issue_pc_i;
    logic [`XLEN-1:0]       issue_inst_i;
    logic                   commit_valid_o;
    logic [`REG_ADDR_W-1:0] commit_rd_o;
    logic                   commit_rd_en_o;
    logic [`XLEN-1:0]       commit_wdata_o;
    logic [`XLEN-1:0]       commit_pc_o;
    logic                   halt_o;
    logic [31:0]            commit_count_o;
    core_pkg::op_class_e    stat_sel_i;
    logic [31:0]            stat_count_o;

    integer                 seed;
    int                     cycles;
    int                     timeouts;
    logic [`XLEN-1:0]       rand_inst;

    tb_clock_gen u_clock_gen (
        .clk_o   (clk),
        .reset_o (reset)
    );

    exec_wb_top dut (.*);

    task automatic report_and_finish;
        int errors;
        errors = dut.u_chk.fail_count + timeouts;
        $display("errors: %0d assertion, %0d timeout", dut.u_chk.fail_count, timeouts);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    endtask

    // called on a falling edge, returns on the falling edge after acceptance
    task automatic send_op(input core_pkg::alu_op_e op, input core_pkg::op_class_e cls,
                           input logic [3:0] rd, input logic rd_en,
                           input logic [3:0] rs1, input logic [3:0] rs2,
                           input logic use_imm, input logic [31:0] imm,
                           input logic [31:0] inst);
        logic accepted;
        accepted        = 1'b0;
        issue_op_i      = op;
        issue_class_i   = cls;
        issue_rd_i      = rd;
        issue_rd_en_i   = rd_en;
        issue_rs1_i     = rs1;
        issue_rs2_i     = rs2;
        issue_use_imm_i = use_imm;
        issue_imm_i     = imm;
        issue_inst_i    = inst;
        issue_pc_i      = issue_pc_i + 32'd4;
        issue_valid_i   = 1'b1;
        while (!accepted) begin
            #10 accepted = issue_ready_o;
            @(negedge clk);
        end
        issue_valid_i = 1'b0;
    endtask

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > MAX_CYCLES) begin
            timeouts = timeouts + 1;
            $display("run did not finish within %0d cycles", MAX_CYCLES);
            report_and_finish();
        end
    end

    always @(negedge clk) begin
        stat_sel_i = core_pkg::op_class_e'(cycles % 6);  // walk all classes
    end

    initial begin
        seed = 32'h7d32;
        cycles = 0;
        timeouts = 0;
        issue_valid_i = 1'b0;
        issue_op_i = core_pkg::ADD;
        issue_class_i = core_pkg::ALU;
        issue_rd_i = '0;
        issue_rd_en_i = 1'b0;
        issue_rs1_i = '0;
        issue_rs2_i = '0;
        issue_use_imm_i = 1'b0;
        issue_imm_i = '0;
        issue_pc_i = '0;
        issue_inst_i = '0;
        stat_sel_i = core_pkg::ALU;
        wait (!reset);
        @(negedge clk);

        // fill every register before anything reads it
        for (int r = 1; r < `REG_COUNT; r++) begin
            send_op(core_pkg::PASS_B, core_pkg::ALU, 4'(r), 1'b1, 0, 0, 1'b1,
                    $random(seed), 0);
        end

        for (int n = 0; n < 300; n++) begin
            rand_inst = $random(seed);
            if (rand_inst == `EBREAK_INST) rand_inst = '0;
            send_op(core_pkg::alu_op_e'({$random(seed)} % 9),
                    core_pkg::op_class_e'({$random(seed)} % 6),
                    4'($random(seed)), 1'($random(seed)),
                    4'($random(seed)), 4'($random(seed)),
                    1'($random(seed)), $random(seed), rand_inst);
        end

        // x0 ignores writes
        send_op(core_pkg::PASS_B, core_pkg::ALU, 0, 1'b1, 0, 0, 1'b1, 32'hdead_beef, 0);
        send_op(core_pkg::ADD, core_pkg::ALU, 3, 1'b1, 0, 0, 1'b1, 32'h0000_1234, 0);
        send_op(core_pkg::PASS_B, core_pkg::ALU, 4, 1'b1, 0, 0, 1'b0, 0, 0);

        // dependent pairs stall one cycle
        send_op(core_pkg::ADD, core_pkg::ALU, 5, 1'b1, 3, 0, 1'b1, 32'h10, 0);
        send_op(core_pkg::SUB, core_pkg::ALU, 6, 1'b1, 5, 3, 1'b0, 0, 0);
        send_op(core_pkg::XOR, core_pkg::ALU, 7, 1'b1, 2, 6, 1'b0, 0, 0);

        // independent pair
        send_op(core_pkg::OR, core_pkg::ALU, 8, 1'b1, 1, 2, 1'b0, 0, 0);
        send_op(core_pkg::AND, core_pkg::ALU, 9, 1'b1, 3, 4, 1'b0, 0, 0);

        send_op(core_pkg::ADD, core_pkg::SYSTEM, 0, 1'b0, 0, 0, 1'b1, 0, `EBREAK_INST);

        // issue must stay blocked once halted
        issue_op_i = core_pkg::ADD;
        issue_class_i = core_pkg::ALU;
        issue_valid_i = 1'b1;
        repeat (8) @(negedge clk);
        issue_valid_i = 1'b0;
        repeat (2) @(negedge clk);
        report_and_finish();
    end

endmodule

//--- vlog.f
+incdir+verilog
verilog/core_pkg.sv
verilog/commit_if.sv
verilog/register_file.sv
verilog/execute_stage.sv
verilog/writeback_stage.sv
verilog/exec_wb_top.sv
sim/tb_clock_gen.sv
sim/exec_wb_chk.sv
sim/exec_wb_tb.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module exec_wb_tb \
    -f vlog.f -o exec_wb_sim

output=$(./obj_dir/exec_wb_sim +verilator+error+limit+1000 || true)
echo "$output"

if echo "$output" | grep -qx "Test OK"; then
    exit 0
else
    exit 1
fi
